// ==== sources.f ====
hw/bit_merge_pkg.sv
hw/bit_rd_if.sv
hw/bit_fifo.sv
hw/bit_merger.sv
hw/bit_merge_top.sv
bench/bit_merge_properties.sv
bench/bit_merge_checker.sv
bench/tb_bit_merge.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the bit merger testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_bit_merge -f sources.f -o sim_bit_merge

sim_out=$(./obj_dir/sim_bit_merge || true)
printf '%s\n' "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "Everything OK"; then
   exit 0
fi
exit 1

// ==== bench/tb_bit_merge.sv ====
`timescale 1ns/1ps

module tb_bit_merge;

   localparam int CLK_PERIOD   = 4;
   localparam int RESET_CYCLES = 8;
   // producer cycles per loaded phase, each cycle may write both channels
   localparam int STIM_CYCLES  = 60;
   // the clear test loads twice, the other data tests once
   localparam int LOAD_PHASES  = 6;
   localparam int TOTAL_WRITES = 2 * STIM_CYCLES * LOAD_PHASES;
   localparam int WATCHDOG_CYCLES = TOTAL_WRITES * 50;

   logic                  clk;
   logic                  arst_n;
   logic                  clear;
   logic                  write_a;
   bit_merge_pkg::cnt_t   wwidth_a;
   bit_merge_pkg::data_t  wdata_a;
   bit_merge_pkg::cnt_t   wlevel_a;
   logic                  write_b;
   bit_merge_pkg::cnt_t   wwidth_b;
   bit_merge_pkg::data_t  wdata_b;
   bit_merge_pkg::cnt_t   wlevel_b;
   bit_merge_pkg::cnt_t   field_a_w;
   bit_merge_pkg::cnt_t   field_b_w;
   bit_merge_pkg::order_e order;
   bit_merge_pkg::data_t  word;
   logic                  word_valid;

   int          test_id;
   logic        test_end;
   int          tests_run;
   int          error_count;
   int          word_count;
   logic [31:0] lfsr_q;

   bit_merge_top i_dut (
      .clk_i        (clk),
      .arst_n_i     (arst_n),
      .clear_i      (clear),
      .write_a_i    (write_a),
      .wwidth_a_i   (wwidth_a),
      .wdata_a_i    (wdata_a),
      .wlevel_a_o   (wlevel_a),
      .write_b_i    (write_b),
      .wwidth_b_i   (wwidth_b),
      .wdata_b_i    (wdata_b),
      .wlevel_b_o   (wlevel_b),
      .field_a_w_i  (field_a_w),
      .field_b_w_i  (field_b_w),
      .order_i      (order),
      .word_o       (word),
      .word_valid_o (word_valid)
   );

   bit_merge_checker i_checker (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .clear_i       (clear),
      .write_a_i     (write_a),
      .wwidth_a_i    (wwidth_a),
      .wdata_a_i     (wdata_a),
      .wlevel_a_i    (wlevel_a),
      .write_b_i     (write_b),
      .wwidth_b_i    (wwidth_b),
      .wdata_b_i     (wdata_b),
      .wlevel_b_i    (wlevel_b),
      .field_a_w_i   (field_a_w),
      .field_b_w_i   (field_b_w),
      .order_i       (order),
      .word_i        (word),
      .word_valid_i  (word_valid),
      .test_id_i     (test_id),
      .test_end_i    (test_end),
      .error_count_o (error_count),
      .word_count_o  (word_count)
   );

   // x^32 + x^22 + x^2 + x + 1, shifting towards the MSB
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one LFSR step for every bit taken
   function automatic logic [31:0] draw_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         v      = {v[30:0], lfsr_q[0]};
      end
      draw_bits = v;
   endfunction

   // one producer cycle on both channels, right after a falling edge
   task automatic drive_producers(input bit busy);
      logic [31:0] coin;
      int          w;
      coin     = draw_bits(1);
      w        = int'(draw_bits(5)) % bit_merge_pkg::DATA_W + 1;
      write_a  = (busy || coin[0]) && (w <= int'(wlevel_a));
      wwidth_a = bit_merge_pkg::cnt_t'(w);
      wdata_a  = bit_merge_pkg::data_t'(draw_bits(bit_merge_pkg::DATA_W));
      coin     = draw_bits(1);
      w        = int'(draw_bits(5)) % bit_merge_pkg::DATA_W + 1;
      write_b  = (busy || coin[0]) && (w <= int'(wlevel_b));
      wwidth_b = bit_merge_pkg::cnt_t'(w);
      wdata_b  = bit_merge_pkg::data_t'(draw_bits(bit_merge_pkg::DATA_W));
   endtask

   task automatic load_phase(input bit busy);
      repeat (STIM_CYCLES) begin
         @(negedge clk);
         drive_producers(busy);
      end
      @(negedge clk);
      write_a = 1'b0;
      write_b = 1'b0;
   endtask

   // wait until one channel no longer holds a whole field
   task automatic drain();
      @(negedge clk);
      while ((bit_merge_pkg::FIFO_BITS - int'(wlevel_a) >= int'(field_a_w)) &&
             (bit_merge_pkg::FIFO_BITS - int'(wlevel_b) >= int'(field_b_w))) begin
         @(negedge clk);
      end
   endtask

   // empties both channels, then sets the new field layout
   task automatic begin_test(input int id, input bit_merge_pkg::order_e ord,
                             input int fa, input int fb);
      clear = 1'b1;
      @(negedge clk);
      clear     = 1'b0;
      test_id   = id;
      order     = ord;
      field_a_w = bit_merge_pkg::cnt_t'(fa);
      field_b_w = bit_merge_pkg::cnt_t'(fb);
   endtask

   task automatic end_test();
      test_end = 1'b1;
      @(negedge clk);
      test_end  = 1'b0;
      tests_run = tests_run + 1;
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: test sequence still running after %0d cycles", WATCHDOG_CYCLES);
      $display("Something failed");
      $finish;
   end

   initial begin
      lfsr_q    = 32'hf9eb;
      arst_n    = 1'b0;
      clear     = 1'b0;
      write_a   = 1'b0;
      wwidth_a  = '0;
      wdata_a   = '0;
      write_b   = 1'b0;
      wwidth_b  = '0;
      wdata_b   = '0;
      field_a_w = '0;
      field_b_w = '0;
      order     = bit_merge_pkg::ORDER_AB;
      test_id   = 0;
      test_end  = 1'b0;
      tests_run = 0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;

      // idle after reset, levels must read empty
      repeat (6) @(negedge clk);
      end_test();

      begin_test(1, bit_merge_pkg::ORDER_AB, 8, 13);
      load_phase(1'b0);
      drain();
      end_test();

      begin_test(2, bit_merge_pkg::ORDER_BA, 5, 9);
      load_phase(1'b0);
      drain();
      end_test();

      // B never drained, it just fills up
      begin_test(3, bit_merge_pkg::ORDER_AB, 21, 0);
      load_phase(1'b0);
      drain();
      end_test();

      begin_test(4, bit_merge_pkg::ORDER_AB, 8, 13);
      load_phase(1'b1);
      drain();
      end_test();

      // clear with data still queued, then start again
      begin_test(5, bit_merge_pkg::ORDER_BA, 8, 13);
      load_phase(1'b1);
      clear = 1'b1;
      @(negedge clk);
      clear = 1'b0;
      repeat (10) @(negedge clk);
      load_phase(1'b0);
      drain();
      end_test();

      repeat (2) @(negedge clk);
      $display("%0d tests, %0d words checked, %0d errors", tests_run, word_count, error_count);
      if (error_count == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

// ==== bench/bit_merge_checker.sv ====
`timescale 1ns/1ps

module bit_merge_checker (
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  logic                  clear_i,
   input  logic                  write_a_i,
   input  bit_merge_pkg::cnt_t   wwidth_a_i,
   input  bit_merge_pkg::data_t  wdata_a_i,
   input  bit_merge_pkg::cnt_t   wlevel_a_i,
   input  logic                  write_b_i,
   input  bit_merge_pkg::cnt_t   wwidth_b_i,
   input  bit_merge_pkg::data_t  wdata_b_i,
   input  bit_merge_pkg::cnt_t   wlevel_b_i,
   input  bit_merge_pkg::cnt_t   field_a_w_i,
   input  bit_merge_pkg::cnt_t   field_b_w_i,
   input  bit_merge_pkg::order_e order_i,
   input  bit_merge_pkg::data_t  word_i,
   input  logic                  word_valid_i,
   input  int                    test_id_i,
   input  logic                  test_end_i,
   output int                    error_count_o,
   output int                    word_count_o
);

   // queued bits of each channel, oldest at the front
   bit q_a[$];
   bit q_b[$];

   // inputs as the DUT took them at the last rising edge
   logic                  in_reset = 1'b1;
   logic                  clr_s;
   logic                  wr_a_s;
   logic                  wr_b_s;
   bit_merge_pkg::cnt_t   ww_a_s;
   bit_merge_pkg::cnt_t   ww_b_s;
   bit_merge_pkg::data_t  wd_a_s;
   bit_merge_pkg::data_t  wd_b_s;
   bit_merge_pkg::cnt_t   fa_s;
   bit_merge_pkg::cnt_t   fb_s;
   bit_merge_pkg::order_e ord_s;
   int                    id_s;
   logic                  end_s;

   int errors      = 0;
   int words       = 0;
   int test_errors = 0;
   int test_words  = 0;

   assign error_count_o = errors;
   assign word_count_o  = words;

   function automatic string test_name(input int id);
      case (id)
         0:       test_name = "after_reset";
         1:       test_name = "order_ab_8_13";
         2:       test_name = "order_ba_5_9";
         3:       test_name = "a_only_21";
         4:       test_name = "back_pressure";
         5:       test_name = "clear_restart";
         default: test_name = "unknown";
      endcase
   endfunction

   task automatic mismatch(input string what, input int expected, input int actual);
      $display("Mismatch in test %s on %s: expected %0d (0x%0h), actual %0d (0x%0h)",
               test_name(id_s), what, expected, expected, actual, actual);
      errors      = errors + 1;
      test_errors = test_errors + 1;
   endtask

   always @(posedge clk_i) begin
      in_reset <= !arst_n_i;
      clr_s    <= clear_i;
      wr_a_s   <= write_a_i;
      wr_b_s   <= write_b_i;
      ww_a_s   <= wwidth_a_i;
      ww_b_s   <= wwidth_b_i;
      wd_a_s   <= wdata_a_i;
      wd_b_s   <= wdata_b_i;
      fa_s     <= field_a_w_i;
      fb_s     <= field_b_w_i;
      ord_s    <= order_i;
      id_s     <= test_id_i;
      end_s    <= test_end_i;
   end

   // outputs are settled half a cycle after the edge
   always @(negedge clk_i) begin
      bit_merge_pkg::data_t exp_word;
      int                   pos;
      int                   n;
      bit                   take_a;
      bit                   exp_valid;

      // a word is due when both queues held their field before the last edge
      exp_valid = !in_reset && !clr_s && (int'(fa_s) + int'(fb_s) > 0) &&
                  (q_a.size() >= int'(fa_s)) && (q_b.size() >= int'(fb_s));

      if (!in_reset && (word_valid_i !== exp_valid)) begin
         if (word_valid_i === 1'b1) begin
            $display("Test %s: unexpected word_valid_o with %0d A bits and %0d B bits queued",
                     test_name(id_s), q_a.size(), q_b.size());
         end else begin
            $display("Test %s: word_valid_o missing with %0d A bits and %0d B bits queued",
                     test_name(id_s), q_a.size(), q_b.size());
         end
         errors      = errors + 1;
         test_errors = test_errors + 1;
      end else if (exp_valid) begin
         words      = words + 1;
         test_words = test_words + 1;
         // first field from the top, second right under it, zeros below
         exp_word = '0;
         pos      = bit_merge_pkg::DATA_W - 1;
         for (int k = 0; k < 2; k++) begin
            take_a = (k == 0) == (ord_s == bit_merge_pkg::ORDER_AB);
            n      = take_a ? int'(fa_s) : int'(fb_s);
            for (int i = 0; i < n; i++) begin
               if (take_a) begin
                  exp_word[pos] = q_a.pop_front();
               end else begin
                  exp_word[pos] = q_b.pop_front();
               end
               pos = pos - 1;
            end
         end
         if (word_i !== exp_word) begin
            mismatch("word_o", int'(exp_word), int'(word_i));
         end
      end

      if (in_reset || clr_s) begin
         q_a.delete();
         q_b.delete();
      end else begin
         // fields enter MSB-first
         if (wr_a_s) begin
            for (int i = 0; i < int'(ww_a_s); i++) begin
               q_a.push_back(wd_a_s[bit_merge_pkg::DATA_W-1-i]);
            end
         end
         if (wr_b_s) begin
            for (int i = 0; i < int'(ww_b_s); i++) begin
               q_b.push_back(wd_b_s[bit_merge_pkg::DATA_W-1-i]);
            end
         end
      end

      if (!in_reset) begin
         if (int'(wlevel_a_i) != bit_merge_pkg::FIFO_BITS - q_a.size()) begin
            mismatch("wlevel_a_o", bit_merge_pkg::FIFO_BITS - q_a.size(), int'(wlevel_a_i));
         end
         if (int'(wlevel_b_i) != bit_merge_pkg::FIFO_BITS - q_b.size()) begin
            mismatch("wlevel_b_o", bit_merge_pkg::FIFO_BITS - q_b.size(), int'(wlevel_b_i));
         end
      end

      if (end_s) begin
         $display("test %s: %0d words, %0d errors", test_name(id_s), test_words, test_errors);
         test_words  = 0;
         test_errors = 0;
      end
   end

endmodule

// ==== bench/bit_merge_properties.sv ====
`timescale 1ns/1ps

module bit_merge_properties (
   input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic                write_a_i,
   input  bit_merge_pkg::cnt_t wwidth_a_i,
   input  bit_merge_pkg::cnt_t wlevel_a_i,
   input  logic                rd_a_i,
   input  bit_merge_pkg::cnt_t rwidth_a_i,
   input  bit_merge_pkg::cnt_t rlevel_a_i,
   input  logic                write_b_i,
   input  bit_merge_pkg::cnt_t wwidth_b_i,
   input  bit_merge_pkg::cnt_t wlevel_b_i,
   input  logic                rd_b_i,
   input  bit_merge_pkg::cnt_t rwidth_b_i,
   input  bit_merge_pkg::cnt_t rlevel_b_i,
   input  logic                word_valid_i
);

   // producers stay within the free space
   a_write_fits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      write_a_i |-> wwidth_a_i <= wlevel_a_i)
      else $error("channel A write of %0d bits with %0d free", wwidth_a_i, wlevel_a_i);
   b_write_fits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      write_b_i |-> wwidth_b_i <= wlevel_b_i)
      else $error("channel B write of %0d bits with %0d free", wwidth_b_i, wlevel_b_i);

   // the merger only draws bits that are there
   a_read_fits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_a_i |-> rlevel_a_i >= rwidth_a_i)
      else $error("channel A read of %0d bits with %0d held", rwidth_a_i, rlevel_a_i);
   b_read_fits: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_b_i |-> rlevel_b_i >= rwidth_b_i)
      else $error("channel B read of %0d bits with %0d held", rwidth_b_i, rlevel_b_i);

   a_levels_sum: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      int'(wlevel_a_i) + int'(rlevel_a_i) == bit_merge_pkg::FIFO_BITS)
      else $error("channel A free and filled levels do not add up to the capacity");
   b_levels_sum: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      int'(wlevel_b_i) + int'(rlevel_b_i) == bit_merge_pkg::FIFO_BITS)
      else $error("channel B free and filled levels do not add up to the capacity");

   quiet_in_reset: assert property (@(posedge clk_i) !arst_n_i |-> !word_valid_i)
      else $error("word_valid_o high during reset");

endmodule

bind bit_merge_top bit_merge_properties i_props (
   .clk_i        (clk_i),
   .arst_n_i     (arst_n_i),
   .write_a_i    (write_a_i),
   .wwidth_a_i   (wwidth_a_i),
   .wlevel_a_i   (wlevel_a_o),
   .rd_a_i       (a_rd.rd),
   .rwidth_a_i   (a_rd.rwidth),
   .rlevel_a_i   (a_rd.rlevel),
   .write_b_i    (write_b_i),
   .wwidth_b_i   (wwidth_b_i),
   .wlevel_b_i   (wlevel_b_o),
   .rd_b_i       (b_rd.rd),
   .rwidth_b_i   (b_rd.rwidth),
   .rlevel_b_i   (b_rd.rlevel),
   .word_valid_i (word_valid_o)
);

// ==== hw/bit_merge_top.sv ====
`timescale 1ns/1ps

module bit_merge_top (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             clear_i,

   // channel A producer
   input  logic                             write_a_i,
   input  logic [bit_merge_pkg::CNT_W-1:0]  wwidth_a_i,
   input  logic [bit_merge_pkg::DATA_W-1:0] wdata_a_i,
   output logic [bit_merge_pkg::CNT_W-1:0]  wlevel_a_o,

   // channel B producer
   input  logic                             write_b_i,
   input  logic [bit_merge_pkg::CNT_W-1:0]  wwidth_b_i,
   input  logic [bit_merge_pkg::DATA_W-1:0] wdata_b_i,
   output logic [bit_merge_pkg::CNT_W-1:0]  wlevel_b_o,

   // merge setup
   input  logic [bit_merge_pkg::CNT_W-1:0]  field_a_w_i,
   input  logic [bit_merge_pkg::CNT_W-1:0]  field_b_w_i,
   input  bit_merge_pkg::order_e            order_i,

   // merged output, cannot be stalled
   output logic [bit_merge_pkg::DATA_W-1:0] word_o,
   output logic                             word_valid_o
);

   // read side of each channel
   bit_rd_if a_rd ();
   bit_rd_if b_rd ();

   bit_fifo i_fifo_a (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .clear_i  (clear_i),
      .write_i  (write_a_i),
      .wwidth_i (wwidth_a_i),
      .wdata_i  (wdata_a_i),
      .wlevel_o (wlevel_a_o),
      .rd       (a_rd.fifo)
   );

   bit_fifo i_fifo_b (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .clear_i  (clear_i),
      .write_i  (write_b_i),
      .wwidth_i (wwidth_b_i),
      .wdata_i  (wdata_b_i),
      .wlevel_o (wlevel_b_o),
      .rd       (b_rd.fifo)
   );

   // draws both channels and packs the word
   bit_merger i_merger (
      .clk_i        (clk_i),
      .arst_n_i     (arst_n_i),
      .clear_i      (clear_i),
      .a_rd         (a_rd.reader),
      .b_rd         (b_rd.reader),
      .field_a_w_i  (field_a_w_i),
      .field_b_w_i  (field_b_w_i),
      .order_i      (order_i),
      .word_o       (word_o),
      .word_valid_o (word_valid_o)
   );

endmodule

// ==== hw/bit_merger.sv ====
`timescale 1ns/1ps

module bit_merger (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             clear_i,

   bit_rd_if.reader                         a_rd,
   bit_rd_if.reader                         b_rd,

   // field_a_w_i + field_b_w_i must not exceed DATA_W
   input  logic [bit_merge_pkg::CNT_W-1:0]  field_a_w_i,
   input  logic [bit_merge_pkg::CNT_W-1:0]  field_b_w_i,
   input  bit_merge_pkg::order_e            order_i,

   output logic [bit_merge_pkg::DATA_W-1:0] word_o,
   output logic                             word_valid_o
);

   logic                 a_ready;
   logic                 b_ready;
   logic                 fire;
   bit_merge_pkg::data_t first_field;
   bit_merge_pkg::data_t second_field;
   bit_merge_pkg::cnt_t  first_w;
   bit_merge_pkg::data_t packed_word;

   // each channel holds at least one field
   assign a_ready = a_rd.rlevel >= field_a_w_i;
   assign b_ready = b_rd.rlevel >= field_b_w_i;

   // an all-zero width setting would only produce empty words
   assign fire = a_ready && b_ready && (|{field_a_w_i, field_b_w_i});

   // both channels are drawn in the same cycle
   assign a_rd.rwidth = field_a_w_i;
   assign b_rd.rwidth = field_b_w_i;
   assign a_rd.rd     = fire;
   assign b_rd.rd     = fire;

   // pick which field leads the word
   always_comb begin
      unique case (order_i)
         bit_merge_pkg::ORDER_AB: begin
            first_field  = a_rd.rdata;
            second_field = b_rd.rdata;
            first_w      = field_a_w_i;
         end
         bit_merge_pkg::ORDER_BA: begin
            first_field  = b_rd.rdata;
            second_field = a_rd.rdata;
            first_w      = field_b_w_i;
         end
         default: begin
            first_field  = a_rd.rdata;
            second_field = b_rd.rdata;
            first_w      = field_a_w_i;
         end
      endcase
   end

   // fields arrive left-aligned with zeros below
   // so the second one just slides in under the first
   assign packed_word = first_field | (second_field >> first_w);

   // valid pulse, one cycle per fire
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         word_valid_o <= 1'b0;
      end else if (clear_i) begin
         word_valid_o <= 1'b0;
      end else begin
         word_valid_o <= fire;
      end
   end

   // output word, held until the next fire
   always_ff @(posedge clk_i) begin
      if (fire && !clear_i) begin
         word_o <= packed_word;
      end
   end

endmodule

// ==== hw/bit_fifo.sv ====
`timescale 1ns/1ps

module bit_fifo (
   input  logic                             clk_i,
   input  logic                             arst_n_i,
   input  logic                             clear_i,

   input  logic                             write_i,
   input  logic [bit_merge_pkg::CNT_W-1:0]  wwidth_i,
   input  logic [bit_merge_pkg::DATA_W-1:0] wdata_i,
   output logic [bit_merge_pkg::CNT_W-1:0]  wlevel_o,

   bit_rd_if.fifo                           rd
);

   // rotate towards the LSB end, s below FIFO_BITS
   function automatic bit_merge_pkg::store_t rot_right(
      input bit_merge_pkg::store_t x,
      input bit_merge_pkg::cnt_t   s
   );
      rot_right = (x >> s) | (x << (bit_merge_pkg::FIFO_BITS - s));
   endfunction

   // rotate towards the MSB end, s below FIFO_BITS
   function automatic bit_merge_pkg::store_t rot_left(
      input bit_merge_pkg::store_t x,
      input bit_merge_pkg::cnt_t   s
   );
      rot_left = (x << s) | (x >> (bit_merge_pkg::FIFO_BITS - s));
   endfunction

   // w ones at the MSB end of a field
   function automatic bit_merge_pkg::data_t lead_mask(
      input bit_merge_pkg::cnt_t w
   );
      lead_mask = ~({bit_merge_pkg::DATA_W{1'b1}} >> w);
   endfunction

   // advance a pointer, wrapping modulo FIFO_BITS
   function automatic bit_merge_pkg::cnt_t ptr_add(
      input bit_merge_pkg::cnt_t p,
      input bit_merge_pkg::cnt_t w
   );
      logic [bit_merge_pkg::CNT_W:0] sum;
      sum = {1'b0, p} + {1'b0, w};
      if (sum >= {1'b0, bit_merge_pkg::FULL_LEVEL}) begin
         sum = sum - {1'b0, bit_merge_pkg::FULL_LEVEL};
      end
      ptr_add = sum[bit_merge_pkg::CNT_W-1:0];
   endfunction

   // storage position 0 sits at the MSB of store_q
   bit_merge_pkg::store_t store_q;
   bit_merge_pkg::cnt_t   wptr_q;
   bit_merge_pkg::cnt_t   rptr_q;
   bit_merge_pkg::cnt_t   level_q;

   bit_merge_pkg::data_t  wfield_mask;
   bit_merge_pkg::store_t wdata_rot;
   bit_merge_pkg::store_t wmask_rot;
   bit_merge_pkg::store_t rdata_rot;
   bit_merge_pkg::cnt_t   add_w;
   bit_merge_pkg::cnt_t   sub_r;

   // only the leading wwidth bits of the field are kept
   assign wfield_mask = lead_mask(wwidth_i);

   // field and mask moved to the write pointer
   assign wdata_rot = rot_right({wdata_i & wfield_mask, {bit_merge_pkg::DATA_W{1'b0}}}, wptr_q);
   assign wmask_rot = rot_right({wfield_mask, {bit_merge_pkg::DATA_W{1'b0}}}, wptr_q);

   // oldest bit brought up to the MSB
   assign rdata_rot = rot_left(store_q, rptr_q);

   assign rd.rdata  = rdata_rot[bit_merge_pkg::FIFO_BITS-1 -: bit_merge_pkg::DATA_W]
                      & lead_mask(rd.rwidth);
   assign rd.rlevel = level_q;
   assign wlevel_o  = bit_merge_pkg::FULL_LEVEL - level_q;

   // zero-width strobes leave the level alone
   assign add_w = write_i ? wwidth_i : '0;
   assign sub_r = rd.rd ? rd.rwidth : '0;

   // pointers and fill count
   always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else if (clear_i) begin
         wptr_q  <= '0;
         rptr_q  <= '0;
         level_q <= '0;
      end else begin
         if (write_i) begin
            wptr_q <= ptr_add(wptr_q, wwidth_i);
         end
         if (rd.rd) begin
            rptr_q <= ptr_add(rptr_q, rd.rwidth);
         end
         // read and write may land in the same cycle
         level_q <= level_q + add_w - sub_r;
      end
   end

   // bit storage
   // a write only touches free positions, so a read in the same cycle is safe
   always_ff @(posedge clk_i) begin
      if (write_i && !clear_i) begin
         store_q <= (store_q & ~wmask_rot) | wdata_rot;
      end
   end

endmodule

// ==== hw/bit_rd_if.sv ====
`timescale 1ns/1ps

interface bit_rd_if;

   // read strobe and width, from the reader
   logic                             rd;
   logic [bit_merge_pkg::CNT_W-1:0]  rwidth;

   // oldest rwidth bits, MSB-first with zeros below
   logic [bit_merge_pkg::DATA_W-1:0] rdata;

   // number of bits currently held
   logic [bit_merge_pkg::CNT_W-1:0]  rlevel;

   modport fifo (
      input  rd,
      input  rwidth,
      output rdata,
      output rlevel
   );

   modport reader (
      output rd,
      output rwidth,
      input  rdata,
      input  rlevel
   );

endinterface

// ==== hw/bit_merge_pkg.sv ====
package bit_merge_pkg;

   // width of one producer field and of one merged output word
   localparam int DATA_W = 21;

   // storage of one bit FIFO, room for two full fields
   localparam int FIFO_BITS = 2 * DATA_W;

   // widths and levels run from 0 up to FIFO_BITS
   localparam int CNT_W = $clog2(FIFO_BITS + 1);

   typedef logic [CNT_W-1:0]     cnt_t;
   typedef logic [DATA_W-1:0]    data_t;
   typedef logic [FIFO_BITS-1:0] store_t;

   // fill level of a full FIFO, as a level-sized value
   localparam cnt_t FULL_LEVEL = cnt_t'(FIFO_BITS);

   // field order of the merged word
   // ORDER_AB puts channel A at the MSB end
   typedef enum logic {
      ORDER_AB = 1'b0,
      ORDER_BA = 1'b1
   } order_e;

endpackage
